// File: design/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;
    localparam int DMEM_WORDS = 256;   // 64-bit words, 2 KiB
    localparam int DMEM_IDX_W = 8;

    localparam logic [XLEN-1:0] PC_RESET = 64'h0000_0000_8000_0000;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,   // byte
        SIZE_H = 2'd1,   // half
        SIZE_W = 2'd2,   // word
        SIZE_D = 2'd3    // double
    } mem_size_e;

    // bundle handed over by execute
    typedef struct packed {
        logic                  valid;
        logic                  rd_wen;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic [XLEN-1:0]       alu_res;       // doubles as the memory address
        logic [XLEN-1:0]       store_data;
        mem_op_e               mem_op;
        mem_size_e             mem_size;
        logic                  load_unsigned;
        logic                  ebreak;
        logic [XLEN-1:0]       pc;
    } ex_mem_t;

    // bundle after the memory access
    typedef struct packed {
        logic                  valid;
        logic                  rd_wen;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic [XLEN-1:0]       alu_res;
        logic                  is_load;
        mem_size_e             mem_size;
        logic                  load_unsigned;
        logic [2:0]            byte_off;      // low address bits
        logic                  ebreak;
        logic [XLEN-1:0]       pc;
    } mem_wb_t;

    localparam ex_mem_t EX_MEM_EMPTY = '{
        valid:         1'b0,
        rd_wen:        1'b0,
        rd_addr:       '0,
        alu_res:       '0,
        store_data:    '0,
        mem_op:        MEM_NONE,
        mem_size:      SIZE_B,
        load_unsigned: 1'b0,
        ebreak:        1'b0,
        pc:            PC_RESET
    };

    localparam mem_wb_t MEM_WB_EMPTY = '{
        valid:         1'b0,
        rd_wen:        1'b0,
        rd_addr:       '0,
        alu_res:       '0,
        is_load:       1'b0,
        mem_size:      SIZE_B,
        load_unsigned: 1'b0,
        byte_off:      3'd0,
        ebreak:        1'b0,
        pc:            PC_RESET
    };

endpackage

// File: design/pipe_reg.sv
`timescale 1ns/1ps

// hold-or-load stage register for any packed payload
module pipe_reg #(
    parameter type      payload_t = logic,
    parameter payload_t rst_val   = '0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold_i,
    input  payload_t d_i,
    output payload_t q_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_o <= rst_val;   // empty bundle
        end else if (!hold_i) begin
            q_o <= d_i;
        end
        // under hold the bundle simply stays
    end

endmodule

// File: design/data_mem.sv
`timescale 1ns/1ps

module data_mem (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    hold_i,
    input  rv_pkg::mem_op_e         op_i,
    input  rv_pkg::mem_size_e       size_i,
    input  logic [rv_pkg::XLEN-1:0] addr_i,
    input  logic [rv_pkg::XLEN-1:0] wdata_i,
    output logic [rv_pkg::XLEN-1:0] rd_word_o
);

    logic [rv_pkg::XLEN-1:0]       mem [rv_pkg::DMEM_WORDS];
    logic [rv_pkg::DMEM_IDX_W-1:0] word_idx;
    logic [2:0]                    off;
    logic [7:0]                    byte_mask;
    logic [rv_pkg::XLEN-1:0]       lane_data;
    logic                          do_store;
    logic                          do_load;

    assign word_idx = addr_i[rv_pkg::DMEM_IDX_W+2:3];
    assign off      = addr_i[2:0];

    assign do_store = (op_i == rv_pkg::MEM_STORE) && !hold_i;
    assign do_load  = (op_i == rv_pkg::MEM_LOAD) && !hold_i;

    // lanes touched by the access, address assumed aligned
    always_comb begin
        case (size_i)
            rv_pkg::SIZE_B: byte_mask = 8'b0000_0001 << off;
            rv_pkg::SIZE_H: byte_mask = 8'b0000_0011 << off;
            rv_pkg::SIZE_W: byte_mask = 8'b0000_1111 << off;
            default:        byte_mask = 8'b1111_1111;
        endcase
    end

    assign lane_data = wdata_i << {off, 3'b000};   // move store data into its lanes

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_pkg::DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (do_store) begin
            for (int b = 0; b < 8; b++) begin
                if (byte_mask[b]) begin
                    mem[word_idx][b*8 +: 8] <= lane_data[b*8 +: 8];
                end
            end
        end
    end

    // whole word is registered, lane pick happens in writeback
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_word_o <= '0;
        end else if (do_load) begin
            rd_word_o <= mem[word_idx];
        end
    end

endmodule

// File: design/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  rv_pkg::mem_wb_t               wb_i,
    input  logic                          hold_i,
    input  logic [rv_pkg::XLEN-1:0]       rd_word_i,
    output logic                          rf_wen_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rf_waddr_o,
    output logic [rv_pkg::XLEN-1:0]       rf_wdata_o,
    output logic                          commit_valid_o,
    output logic [rv_pkg::XLEN-1:0]       commit_pc_o,
    output logic                          halted_o,
    output logic [rv_pkg::XLEN-1:0]       halt_pc_o
);

    logic [rv_pkg::XLEN-1:0] shifted;
    logic [rv_pkg::XLEN-1:0] load_val;
    logic                    sx;   // fill bit for the upper part

    assign shifted = rd_word_i >> {wb_i.byte_off, 3'b000};

    always_comb begin
        case (wb_i.mem_size)
            rv_pkg::SIZE_B: begin
                sx       = shifted[7] & ~wb_i.load_unsigned;
                load_val = {{(rv_pkg::XLEN-8){sx}}, shifted[7:0]};
            end
            rv_pkg::SIZE_H: begin
                sx       = shifted[15] & ~wb_i.load_unsigned;
                load_val = {{(rv_pkg::XLEN-16){sx}}, shifted[15:0]};
            end
            rv_pkg::SIZE_W: begin
                sx       = shifted[31] & ~wb_i.load_unsigned;
                load_val = {{(rv_pkg::XLEN-32){sx}}, shifted[31:0]};
            end
            default: begin
                sx       = 1'b0;
                load_val = rd_word_i;   // double, no extension
            end
        endcase
    end

    // a held bundle rewrites the same value, harmless
    assign rf_wen_o   = wb_i.valid & wb_i.rd_wen;
    assign rf_waddr_o = wb_i.rd_addr;
    assign rf_wdata_o = wb_i.is_load ? load_val : wb_i.alu_res;

    assign commit_valid_o = wb_i.valid & ~hold_i;   // report each commit once
    assign commit_pc_o    = wb_i.pc;

    // sticky until reset, first ebreak pc kept
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted_o  <= 1'b0;
            halt_pc_o <= rv_pkg::PC_RESET;
        end else if (commit_valid_o && wb_i.ebreak && !halted_o) begin
            halted_o  <= 1'b1;
            halt_pc_o <= wb_i.pc;
        end
    end

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wen_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [rv_pkg::XLEN-1:0]       wdata_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] raddr_i,
    output logic [rv_pkg::XLEN-1:0]       rdata_o
);

    localparam int NREGS = 2 ** rv_pkg::REG_ADDR_W;

    logic [rv_pkg::XLEN-1:0] regs [NREGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && (waddr_i != '0)) begin   // x0 writes dropped
            regs[waddr_i] <= wdata_i;
        end
    end

    // combinational read, x0 forced to zero
    assign rdata_o = (raddr_i == '0) ? '0 : regs[raddr_i];

endmodule

// File: design/mem_wb_top.sv
`timescale 1ns/1ps

module mem_wb_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          ex_valid_i,
    input  rv_pkg::ex_mem_t               ex_bundle_i,
    input  logic                          hold_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs_addr_i,
    output logic [rv_pkg::XLEN-1:0]       rs_data_o,
    output logic                          commit_valid_o,
    output logic [rv_pkg::XLEN-1:0]       commit_pc_o,
    output logic                          halted_o,
    output logic [rv_pkg::XLEN-1:0]       halt_pc_o
);

    rv_pkg::ex_mem_t               ex_d;
    rv_pkg::ex_mem_t               ex_q;
    rv_pkg::mem_wb_t               wb_d;
    rv_pkg::mem_wb_t               wb_q;
    logic [rv_pkg::XLEN-1:0]       rd_word;
    logic                          rf_wen;
    logic [rv_pkg::REG_ADDR_W-1:0] rf_waddr;
    logic [rv_pkg::XLEN-1:0]       rf_wdata;

    // bubble when the strobe is low
    always_comb begin
        if (ex_valid_i) begin
            ex_d       = ex_bundle_i;
            ex_d.valid = 1'b1;
        end else begin
            ex_d = rv_pkg::EX_MEM_EMPTY;
        end
    end

    pipe_reg #(
        .payload_t (rv_pkg::ex_mem_t),
        .rst_val   (rv_pkg::EX_MEM_EMPTY)
    ) u_ex_mem (
        .clk    (clk),
        .rst_n  (rst_n),
        .hold_i (hold_i),
        .d_i    (ex_d),
        .q_o    (ex_q)
    );

    data_mem u_dmem (
        .clk       (clk),
        .rst_n     (rst_n),
        .hold_i    (hold_i),
        .op_i      (ex_q.mem_op),
        .size_i    (ex_q.mem_size),
        .addr_i    (ex_q.alu_res),
        .wdata_i   (ex_q.store_data),
        .rd_word_o (rd_word)
    );

    // MEM/WB payload, store data is no longer needed past here
    always_comb begin
        wb_d.valid         = ex_q.valid;
        wb_d.rd_wen        = ex_q.rd_wen;
        wb_d.rd_addr       = ex_q.rd_addr;
        wb_d.alu_res       = ex_q.alu_res;
        wb_d.is_load       = (ex_q.mem_op == rv_pkg::MEM_LOAD);
        wb_d.mem_size      = ex_q.mem_size;
        wb_d.load_unsigned = ex_q.load_unsigned;
        wb_d.byte_off      = ex_q.alu_res[2:0];
        wb_d.ebreak        = ex_q.ebreak;
        wb_d.pc            = ex_q.pc;
    end

    pipe_reg #(
        .payload_t (rv_pkg::mem_wb_t),
        .rst_val   (rv_pkg::MEM_WB_EMPTY)
    ) u_mem_wb (
        .clk    (clk),
        .rst_n  (rst_n),
        .hold_i (hold_i),
        .d_i    (wb_d),
        .q_o    (wb_q)
    );

    wb_stage u_wb (
        .clk            (clk),
        .rst_n          (rst_n),
        .wb_i           (wb_q),
        .hold_i         (hold_i),
        .rd_word_i      (rd_word),
        .rf_wen_o       (rf_wen),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .halted_o       (halted_o),
        .halt_pc_o      (halt_pc_o)
    );

    reg_file u_rf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wen_i   (rf_wen),
        .waddr_i (rf_waddr),
        .wdata_i (rf_wdata),
        .raddr_i (rs_addr_i),
        .rdata_o (rs_data_o)
    );

endmodule

// File: bench/tb_clk.sv
`timescale 1ns/1ps

// free running clock and power-on reset for the testbench
module tb_clk #(
    parameter int HALF_PERIOD = 10,   // ns, gives the 20 ns period
    parameter int RST_CYCLES  = 2
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #2;
        rst_n_o = 1'b1;   // release away from the edge
    end

endmodule

// File: bench/mem_wb_assert.sv
`timescale 1ns/1ps

// protocol and register file checks, bound into mem_wb_top
module mem_wb_assert (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          ex_valid_i,
    input logic                          hold_i,
    input logic                          commit_valid_o,
    input logic [rv_pkg::REG_ADDR_W-1:0] rs_addr_i,
    input logic [rv_pkg::XLEN-1:0]       rs_data_o
);

    int unsigned fail_count = 0;   // collected by tb_top at the end

    // the source may not strobe while the pipe is frozen
    a_no_strobe_in_hold: assert property (
        @(posedge clk) disable iff (!rst_n) hold_i |-> !ex_valid_i
    ) else begin
        fail_count++;
        $error("ex_valid_i high while hold_i is high");
    end

    a_x0_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_n) (rs_addr_i == '0) |-> (rs_data_o == '0)
    ) else begin
        fail_count++;
        $error("register x0 read back nonzero");
    end

    a_no_commit_in_hold: assert property (
        @(posedge clk) disable iff (!rst_n) hold_i |-> !commit_valid_o
    ) else begin
        fail_count++;
        $error("commit_valid_o high while hold_i is high");
    end

endmodule

// File: bench/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    logic                          clk;
    logic                          rst_n;
    logic                          ex_valid;
    rv_pkg::ex_mem_t               ex_bundle;
    logic                          hold;
    logic [rv_pkg::REG_ADDR_W-1:0] rs_addr;
    logic [rv_pkg::XLEN-1:0]       rs_data;
    logic                          commit_valid;
    logic [rv_pkg::XLEN-1:0]       commit_pc;
    logic                          halted;
    logic [rv_pkg::XLEN-1:0]       halt_pc;

    logic [rv_pkg::XLEN-1:0] pc_q [$];   // sent pcs waiting for their commit
    logic [rv_pkg::XLEN-1:0] exp_pc;
    string                   lines [$];
    int                      seed = 21245;
    int                      n_tests = 0;
    int                      n_checks = 0;
    int                      n_errors = 0;
    int                      n_sent = 0;
    int                      n_commits = 0;

    tb_clk u_clk (.clk_o(clk), .rst_n_o(rst_n));

    mem_wb_top dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex_valid_i     (ex_valid),
        .ex_bundle_i    (ex_bundle),
        .hold_i         (hold),
        .rs_addr_i      (rs_addr),
        .rs_data_o      (rs_data),
        .commit_valid_o (commit_valid),
        .commit_pc_o    (commit_pc),
        .halted_o       (halted),
        .halt_pc_o      (halt_pc)
    );

    bind mem_wb_top mem_wb_assert u_assert (.*);

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("MISMATCH at %0d ns: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic report_test(input string desc, input int errs_before);
        n_tests++;
        $display("test %0d %s: %s", n_tests, desc, (n_errors == errs_before) ? "pass" : "fail");
    endtask

    // every commit must match the oldest pc still in flight
    always @(negedge clk) begin
        if (rst_n && commit_valid) begin
            n_commits++;
            if (pc_q.size() == 0) begin
                n_errors++;
                $display("commit of pc %h at %0d ns with no bundle in flight", commit_pc, $time);
            end else begin
                exp_pc = pc_q.pop_front();
                check_val("commit_pc_o", exp_pc, commit_pc);
            end
        end
    end

    task automatic load_file(output bit ok);
        int    fd;
        string line;
        fd = $fopen("bench/stim_input.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fgets(line, fd) > 0) begin
                lines.push_back(line);
            end
            $fclose(fd);
        end
    endtask

    // entered and left 2 ns after a rising edge
    task automatic send_op(input rv_pkg::ex_mem_t b, input int hold_cycles);
        int gap;
        ex_bundle = b;
        ex_valid  = 1'b1;
        pc_q.push_back(b.pc);
        n_sent++;
        @(posedge clk);
        #2;
        ex_valid  = 1'b0;
        ex_bundle = rv_pkg::EX_MEM_EMPTY;
        if (hold_cycles > 0) begin
            hold = 1'b1;
            repeat (hold_cycles) begin
                @(posedge clk);
                #2;
            end
            hold = 1'b0;
        end
        gap = $unsigned($random(seed)) % 3;   // bubbles in between
        repeat (gap) begin
            @(posedge clk);
            #2;
        end
    endtask

    // last commit is written at the edge after it shows
    task automatic drain();
        while (pc_q.size() != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic run_line(input string line);
        rv_pkg::ex_mem_t b;
        logic                          wen;
        logic [rv_pkg::REG_ADDR_W-1:0] idx;
        logic [63:0]                   v0;
        logic [63:0]                   v1;
        logic [63:0]                   pc;
        logic [1:0]                    op;
        logic [1:0]                    size;
        logic                          uns;
        logic                          ebr;
        int                            hold_n;
        int                            n;
        int                            errs;
        byte                           tag;
        tag  = line.getc(0);
        errs = n_errors;
        case (tag)
            "O": begin
                n = $sscanf(line, "O %h %h %h %h %h %h %h %h %h %d",
                            wen, idx, v0, v1, op, size, uns, ebr, pc, hold_n);
                b               = rv_pkg::EX_MEM_EMPTY;
                b.valid         = 1'b1;
                b.rd_wen        = wen;
                b.rd_addr       = idx;
                b.alu_res       = v0;
                b.store_data    = v1;
                b.mem_op        = rv_pkg::mem_op_e'(op);
                b.mem_size      = rv_pkg::mem_size_e'(size);
                b.load_unsigned = uns;
                b.ebreak        = ebr;
                b.pc            = pc;
                if (n != 10) begin
                    n_errors++;
                    $display("malformed op line in stimulus file: %s", line);
                end else begin
                    send_op(b, hold_n);
                end
            end
            "C": begin
                n = $sscanf(line, "C %h %h", idx, v0);
                drain();
                rs_addr = idx;
                @(negedge clk);
                check_val($sformatf("rs_data_o x%0d", idx), v0, rs_data);
                @(posedge clk);
                #2;
                report_test($sformatf("x%0d readback", idx), errs);
            end
            "H": begin
                n = $sscanf(line, "H %h %h", uns, v0);
                drain();
                @(negedge clk);
                check_val("halted_o", 64'(uns), 64'(halted));
                check_val("halt_pc_o", v0, halt_pc);
                @(posedge clk);
                #2;
                report_test("halt state", errs);
            end
            default: ;   // comment or blank line
        endcase
    endtask

    initial begin : main
        bit ok;
        int errs;
        ex_valid  = 1'b0;
        ex_bundle = rv_pkg::EX_MEM_EMPTY;
        hold      = 1'b0;
        rs_addr   = '0;
        load_file(ok);
        if (!ok) begin
            $display("could not open bench/stim_input.txt");
            $display("Test FAILED");
            $finish;
        end else begin
            fork
                begin
                    repeat (lines.size() * 20) @(posedge clk);
                    $display("watchdog expired after %0d cycles, run did not finish",
                             lines.size() * 20);
                    $display("Test FAILED");
                    $finish;
                end
            join_none
            wait (rst_n === 1'b1);
            @(posedge clk);
            #2;
            foreach (lines[i]) begin
                run_line(lines[i]);
            end
            drain();
            // let any stray bubble reach writeback
            repeat (3) begin
                @(posedge clk);
                #2;
            end
            errs = n_errors;
            check_val("commit count", 64'(n_sent), 64'(n_commits));
            report_test("commit order and count", errs);
            if (dut.u_assert.fail_count != 0) begin
                n_errors += int'(dut.u_assert.fail_count);
                $display("%0d assertion failures during the run", dut.u_assert.fail_count);
            end
            $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
            if (n_errors == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

endmodule

// File: bench/stim_input.txt
# O rd_wen rd alu_res store_data mem_op mem_size unsigned ebreak pc hold_cycles(dec)
# C reg expected_value, H halted halt_pc; other values hex
H 0 80000000
O 1 05 1234 0 0 0 0 0 80000000 0
O 1 00 deadbeef 0 0 0 0 0 80000004 0
C 05 1234
C 00 0
# double store, then loads of every size
O 0 00 100 f1e2d3c4b5a69788 2 3 0 0 80000008 0
O 1 06 100 0 1 0 0 0 8000000c 0
O 1 07 103 0 1 0 1 0 80000010 0
O 1 08 102 0 1 1 0 0 80000014 0
O 1 09 106 0 1 1 1 0 80000018 0
O 1 0a 104 0 1 2 0 0 8000001c 0
O 1 0b 100 0 1 2 1 0 80000020 0
O 1 0c 100 0 1 3 0 0 80000024 0
C 06 ffffffffffffff88
C 07 b5
C 08 ffffffffffffb5a6
C 09 f1e2
C 0a fffffffff1e2d3c4
C 0b b5a69788
C 0c f1e2d3c4b5a69788
# byte store at offset 5, only that lane changes
O 0 00 105 ffffffffffffff5a 2 0 0 0 80000028 0
O 1 0d 100 0 1 3 0 0 8000002c 0
C 0d f1e25ac4b5a69788
# hold after an alu op, a store and a load
O 1 0e cafef00d 0 0 0 0 0 80000030 3
O 0 00 108 11223344 2 2 0 0 80000034 2
O 1 0f 108 0 1 3 0 0 80000038 1
C 0e cafef00d
C 0f 11223344
# ebreak, later bundles still commit
O 0 00 0 0 0 0 0 1 8000003c 1
O 1 10 55 0 0 0 0 0 80000040 0
O 0 00 0 0 0 0 0 1 80000044 0
H 1 8000003c
C 10 55

// File: sim.f
design/rv_pkg.sv
design/pipe_reg.sv
design/data_mem.sv
design/wb_stage.sv
design/reg_file.sv
design/mem_wb_top.sv
bench/tb_clk.sv
bench/mem_wb_assert.sv
bench/tb_top.sv

// File: Makefile
SIM       = verilator
TOP       = tb_top
FILELIST  = sim.f
FLAGS     = --binary --timing --assert --top-module $(TOP)
RUN_FLAGS = +verilator+error+limit+100
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
